// File: Bender.yml
package:
  name: mem_stage

sources:
  - logic/mem_stage_pkg.sv
  - logic/dmem_extender.sv
  - logic/data_access_unit.sv
  - logic/fence_tracker.sv
  - logic/mem_stage.sv
  - target: test
    files:
      - tests/mem_stage_chk.sv
      - tests/mem_stage_tb.sv

// File: logic/data_access_unit.sv
`timescale 1ns/100ps
`default_nettype none

module data_access_unit #(
    parameter bit BIG_ENDIAN_BUS = 1'b0
) (
    input  mem_stage_pkg::load_type_t load_type,
    input  mem_stage_pkg::word_t      alu_out,
    input  mem_stage_pkg::word_t      rs2_data,
    input  logic                      dren,
    input  logic                      dwen,
    input  logic                      suppress_data,
    input  mem_stage_pkg::word_t      dmem_rdata,
    output logic                      dmem_ren,
    output logic                      dmem_wen,
    output mem_stage_pkg::word_t      dmem_addr,
    output logic [3:0]                dmem_byte_en,
    output mem_stage_pkg::word_t      dmem_wdata,
    output mem_stage_pkg::word_t      load_data,
    output logic                      mal_load,
    output logic                      mal_store
);
    import mem_stage_pkg::*;

    logic [1:0] byte_offset;
    logic [3:0] byte_en_std;
    logic       mal_addr;

    // Strobes dropped while the hazard unit squashes the access
    assign dmem_ren    = dren && !suppress_data;
    assign dmem_wen    = dwen && !suppress_data;
    assign dmem_addr   = alu_out;
    assign byte_offset = alu_out[1:0];

    // Lane enables in address order
    always_comb begin
        case (load_type)
            LB, LBU: begin
                case (byte_offset)
                    2'b00:   byte_en_std = 4'b0001;
                    2'b01:   byte_en_std = 4'b0010;
                    2'b10:   byte_en_std = 4'b0100;
                    default: byte_en_std = 4'b1000;
                endcase
            end
            LH, LHU: begin
                case (byte_offset)
                    2'b00:   byte_en_std = 4'b0011;
                    2'b10:   byte_en_std = 4'b1100;
                    default: byte_en_std = 4'b0000;
                endcase
            end
            LW:      byte_en_std = 4'b1111;
            default: byte_en_std = 4'b0000;
        endcase
    end

    // Little-endian bus takes write lanes reversed
    generate
        if (BIG_ENDIAN_BUS) begin : g_bus_be
            assign dmem_byte_en = byte_en_std;
        end else begin : g_bus_le
            assign dmem_byte_en = dren ? byte_en_std
                                       : {byte_en_std[0], byte_en_std[1],
                                          byte_en_std[2], byte_en_std[3]};
        end
    endgenerate

    // Store data copied into every lane
    always_comb begin
        case (load_type)
            LB:      dmem_wdata = {4{rs2_data[7:0]}};
            LH:      dmem_wdata = {2{rs2_data[15:0]}};
            LW:      dmem_wdata = rs2_data;
            default: dmem_wdata = '0;
        endcase
    end

    always_comb begin
        case (load_type)
            LW:      mal_addr = (byte_offset != 2'b00);
            LH, LHU: mal_addr = byte_offset[0];
            default: mal_addr = 1'b0;
        endcase
    end

    assign mal_load  = dmem_ren && mal_addr;
    assign mal_store = dmem_wen && mal_addr;

    dmem_extender u_extender (
        .dmem_rdata (dmem_rdata),
        .load_type  (load_type),
        .byte_en    (dmem_byte_en),
        .ext_out    (load_data)
    );

endmodule

`default_nettype wire

// File: logic/dmem_extender.sv
`timescale 1ns/100ps
`default_nettype none

module dmem_extender (
    input  mem_stage_pkg::word_t      dmem_rdata,
    input  mem_stage_pkg::load_type_t load_type,
    input  logic [3:0]                byte_en,
    output mem_stage_pkg::word_t      ext_out
);
    import mem_stage_pkg::*;

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Lane picked by the byte enables
    always_comb begin
        case (byte_en)
            4'b0010: sel_byte = dmem_rdata[15:8];
            4'b0100: sel_byte = dmem_rdata[23:16];
            4'b1000: sel_byte = dmem_rdata[31:24];
            default: sel_byte = dmem_rdata[7:0];
        endcase
    end

    // Upper half only when lanes 3:2 are enabled
    assign sel_half = (byte_en == 4'b1100) ? dmem_rdata[31:16] : dmem_rdata[15:0];

    always_comb begin
        case (load_type)
            LB:      ext_out = {{24{sel_byte[7]}}, sel_byte};
            LBU:     ext_out = {24'h000000, sel_byte};
            LH:      ext_out = {{16{sel_half[15]}}, sel_half};
            LHU:     ext_out = {16'h0000, sel_half};
            LW:      ext_out = dmem_rdata;
            default: ext_out = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/fence_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module fence_tracker #(
    parameter bit WAIT_DONE = 1'b1
) (
    input  logic CLK,
    input  logic nRST,
    input  logic req,
    input  logic done_a,
    input  logic done_b,
    output logic pulse_a,
    output logic pulse_b,
    output logic stall
);

    logic active;
    logic flag_a;
    logic flag_b;
    logic flag_a_next;
    logic flag_b_next;
    logic pulse;
    logic all_done;

    // First cycle of a request seen while idle
    assign pulse   = req && !active;
    assign pulse_a = pulse;
    assign pulse_b = pulse;

    // A done arriving with the pulse still counts
    always_comb begin
        flag_a_next = flag_a;
        flag_b_next = flag_b;
        if (pulse) begin
            flag_a_next = 1'b0;
            flag_b_next = 1'b0;
        end
        if (done_a) begin
            flag_a_next = 1'b1;
        end
        if (done_b) begin
            flag_b_next = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            active <= 1'b0;
            flag_a <= 1'b1;
            flag_b <= 1'b1;
        end else begin
            // Stays active as long as the request is held
            active <= req;
            flag_a <= flag_a_next;
            flag_b <= flag_b_next;
        end
    end

    // Without waiting, completion is taken as immediate
    assign all_done = (flag_a && flag_b) || !WAIT_DONE;
    assign stall    = active && !all_done;

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage #(
    parameter bit BIG_ENDIAN_BUS = 1'b0,
    parameter bit TLB_WAIT       = 1'b1
) (
    input  logic                      CLK,
    input  logic                      nRST,
    // Execute/memory register fields
    input  logic                      valid,
    input  mem_stage_pkg::word_t      pc,
    input  mem_stage_pkg::word_t      pc4,
    input  mem_stage_pkg::word_t      instr,
    input  mem_stage_pkg::word_t      alu_out,
    input  mem_stage_pkg::word_t      rs2_data,
    input  mem_stage_pkg::word_t      imm_u,
    input  mem_stage_pkg::load_type_t load_type,
    input  mem_stage_pkg::w_sel_t     w_sel,
    input  logic                      dren,
    input  logic                      dwen,
    input  logic                      reg_write_in,
    input  logic [4:0]                rd_in,
    input  logic                      branch,
    input  logic                      branch_taken,
    input  logic                      prediction,
    input  mem_stage_pkg::word_t      predicted_addr,
    input  mem_stage_pkg::word_t      brj_addr,
    input  logic                      ifence,
    input  logic                      sfence,
    input  logic                      halt_in,
    input  logic                      suppress_data,
    input  mem_stage_pkg::word_t      csr_rdata,
    // Data bus
    output logic                      dmem_ren,
    output logic                      dmem_wen,
    output mem_stage_pkg::word_t      dmem_addr,
    output mem_stage_pkg::word_t      dmem_wdata,
    output logic [3:0]                dmem_byte_en,
    input  mem_stage_pkg::word_t      dmem_rdata,
    input  logic                      dmem_busy,
    input  logic                      dmem_error,
    // Cache and TLB control
    output logic                      icache_flush,
    output logic                      dcache_flush,
    output logic                      itlb_fence,
    output logic                      dtlb_fence,
    input  logic                      iflush_done,
    input  logic                      dflush_done,
    input  logic                      itlb_done,
    input  logic                      dtlb_done,
    // Hazard, writeback and forwarding
    output logic                      fence_stall,
    output logic                      mem_busy,
    output logic                      halt,
    output logic                      reg_write,
    output logic [4:0]                rd,
    output mem_stage_pkg::word_t      reg_wdata,
    output mem_stage_pkg::word_t      fw_data,
    output logic                      mal_load,
    output logic                      mal_store,
    output logic                      fault_load,
    output logic                      fault_store,
    // Branch predictor update
    output logic                      mispredict,
    output logic                      update_predictor,
    output logic                      update_taken,
    output mem_stage_pkg::word_t      update_addr,
    output mem_stage_pkg::word_t      update_pc,
    output logic                      update_direction,
    output logic                      is_jalr
);
    import mem_stage_pkg::*;

    word_t dload_ext;
    logic  cache_stall;
    logic  tlb_stall;

    data_access_unit #(
        .BIG_ENDIAN_BUS (BIG_ENDIAN_BUS)
    ) u_access (
        .load_type     (load_type),
        .alu_out       (alu_out),
        .rs2_data      (rs2_data),
        .dren          (dren),
        .dwen          (dwen),
        .suppress_data (suppress_data),
        .dmem_rdata    (dmem_rdata),
        .dmem_ren      (dmem_ren),
        .dmem_wen      (dmem_wen),
        .dmem_addr     (dmem_addr),
        .dmem_byte_en  (dmem_byte_en),
        .dmem_wdata    (dmem_wdata),
        .load_data     (dload_ext),
        .mal_load      (mal_load),
        .mal_store     (mal_store)
    );

    // ifence flushes both caches
    fence_tracker #(
        .WAIT_DONE (1'b1)
    ) u_cache_fence (
        .CLK     (CLK),
        .nRST    (nRST),
        .req     (ifence),
        .done_a  (iflush_done),
        .done_b  (dflush_done),
        .pulse_a (icache_flush),
        .pulse_b (dcache_flush),
        .stall   (cache_stall)
    );

    // sfence invalidates both TLBs
    fence_tracker #(
        .WAIT_DONE (TLB_WAIT)
    ) u_tlb_fence (
        .CLK     (CLK),
        .nRST    (nRST),
        .req     (sfence),
        .done_a  (itlb_done),
        .done_b  (dtlb_done),
        .pulse_a (itlb_fence),
        .pulse_b (dtlb_fence),
        .stall   (tlb_stall)
    );

    assign fence_stall = cache_stall || tlb_stall;
    assign mem_busy    = dmem_busy;
    assign halt        = halt_in;

    // Bus errors split by access direction
    assign fault_load  = dren && dmem_error;
    assign fault_store = dwen && dmem_error;

    // Predictor training, bubbles ignored
    assign update_predictor = branch && valid;
    assign update_taken     = branch_taken;
    assign update_addr      = brj_addr;
    assign update_pc        = pc;
    assign update_direction = instr[31];
    assign mispredict       = (predicted_addr != brj_addr) || (prediction != branch_taken);

    // Return through ra or t0
    assign is_jalr = (instr[6:0] == JALR_OPCODE) &&
                     ((instr[19:15] == 5'd1) || (instr[19:15] == 5'd5));

    assign reg_write = reg_write_in && !suppress_data;
    assign rd        = rd_in;

    always_comb begin
        case (w_sel)
            W_SEL_DLOAD: reg_wdata = dload_ext;
            W_SEL_PC4:   reg_wdata = pc4;
            W_SEL_IMM_U: reg_wdata = imm_u;
            W_SEL_ALU:   reg_wdata = alu_out;
            W_SEL_CSR:   reg_wdata = csr_rdata;
            default:     reg_wdata = '0;
        endcase
    end

    // Load data is not ready for forwarding here
    assign fw_data = (w_sel == W_SEL_DLOAD) ? '0 : reg_wdata;

endmodule

`default_nettype wire

// File: logic/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    // One data or address word
    typedef logic [31:0] word_t;

    // Access width and signedness
    // Codes follow funct3 of the load opcode, stores use LB/LH/LW only
    typedef enum logic [2:0] {
        LB   = 3'b000,
        LH   = 3'b001,
        LW   = 3'b010,
        LBU  = 3'b100,
        LHU  = 3'b101,
        NONE = 3'b111
    } load_type_t;

    // Writeback source select
    typedef enum logic [2:0] {
        W_SEL_DLOAD = 3'd0,
        W_SEL_PC4   = 3'd1,
        W_SEL_IMM_U = 3'd2,
        W_SEL_ALU   = 3'd3,
        W_SEL_CSR   = 3'd4
    } w_sel_t;

    // Major opcode of JALR
    localparam logic [6:0] JALR_OPCODE = 7'b1100111;

endpackage

`default_nettype wire

// File: project.f
logic/mem_stage_pkg.sv
logic/dmem_extender.sv
logic/data_access_unit.sv
logic/fence_tracker.sv
logic/mem_stage.sv
tests/mem_stage_chk.sv
tests/mem_stage_tb.sv

// File: tests/mem_stage_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_chk (
    input logic       CLK,
    input logic       nRST,
    input logic       dmem_ren,
    input logic       dmem_wen,
    input logic [3:0] dmem_byte_en,
    input logic       mal_load,
    input logic       icache_flush,
    input logic       dcache_flush,
    input logic       itlb_fence,
    input logic       dtlb_fence,
    input logic       fence_stall
);

    // Bus is either read or written, never both
    a_one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(dmem_ren && dmem_wen))
        else $error("dmem_ren and dmem_wen both high");

    // Flush and fence requests last a single cycle
    a_iflush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        icache_flush |=> !icache_flush)
        else $error("icache_flush held longer than one cycle");

    a_dflush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        dcache_flush |=> !dcache_flush)
        else $error("dcache_flush held longer than one cycle");

    a_itlb_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        itlb_fence |=> !itlb_fence)
        else $error("itlb_fence held longer than one cycle");

    a_dtlb_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        dtlb_fence |=> !dtlb_fence)
        else $error("dtlb_fence held longer than one cycle");

    a_stall_after_reset: assert property (@(posedge CLK)
        $rose(nRST) |-> !fence_stall)
        else $error("fence_stall high out of reset");

    // An aligned read always enables some lane
    a_read_lanes: assert property (@(posedge CLK) disable iff (!nRST)
        (dmem_ren && !mal_load) |-> (dmem_byte_en != 4'b0000))
        else $error("aligned read with no byte enable");

endmodule

`default_nettype wire

// File: tests/mem_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mem_stage_tb;
    import mem_stage_pkg::*;

    logic       CLK, nRST;
    logic       valid, dren, dwen, reg_write_in, branch, branch_taken, prediction;
    logic       ifence, sfence, halt_in, suppress_data, dmem_busy, dmem_error;
    logic       iflush_done, dflush_done, itlb_done, dtlb_done;
    word_t      pc, pc4, instr, alu_out, rs2_data, imm_u, predicted_addr, brj_addr;
    word_t      csr_rdata, dmem_rdata, dmem_addr, dmem_wdata, reg_wdata, fw_data;
    word_t      update_addr, update_pc;
    load_type_t load_type;
    w_sel_t     w_sel;
    logic [4:0] rd_in, rd;
    logic [3:0] dmem_byte_en;
    logic       dmem_ren, dmem_wen, icache_flush, dcache_flush, itlb_fence, dtlb_fence;
    logic       fence_stall, mem_busy, halt, reg_write, mal_load, mal_store;
    logic       fault_load, fault_store, mispredict, update_predictor, update_taken;
    logic       update_direction, is_jalr;

    integer     seed;
    integer     errors;
    integer     cnt_if, cnt_df, cnt_it, cnt_dt;
    integer     dly_if, dly_df, dly_it, dly_dt;
    logic       seen_if, seen_df, seen_it, seen_dt;

    mem_stage DUT (.*);

    bind mem_stage mem_stage_chk u_chk (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [3:0] lanes_for(load_type_t lt, logic [1:0] off);
        case (lt)
            LB, LBU: return 4'b0001 << off;
            LH, LHU: return off[0] ? 4'b0000 : (off[1] ? 4'b1100 : 4'b0011);
            LW:      return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    // Writes reach a little-endian bus with the lanes reversed
    function automatic logic [3:0] expect_byte_en(load_type_t lt, logic [1:0] off, logic rd_acc);
        logic [3:0] l;
        l = lanes_for(lt, off);
        return rd_acc ? l : {l[0], l[1], l[2], l[3]};
    endfunction

    function automatic word_t expect_wdata(load_type_t lt, word_t v);
        case (lt)
            LB:      return {v[7:0], v[7:0], v[7:0], v[7:0]};
            LH:      return {v[15:0], v[15:0]};
            LW:      return v;
            default: return 32'h0;
        endcase
    endfunction

    function automatic word_t expect_load(load_type_t lt, logic [1:0] off, word_t r);
        word_t sh;
        sh = r >> (8 * off);
        case (lt)
            LB:      return {{24{sh[7]}}, sh[7:0]};
            LBU:     return {24'h0, sh[7:0]};
            LH:      return {{16{sh[15]}}, sh[15:0]};
            LHU:     return {16'h0, sh[15:0]};
            default: return r;
        endcase
    endfunction

    function automatic logic expect_misaligned(load_type_t lt, logic [1:0] off);
        if (lt == LW)
            return off != 2'b00;
        if (lt == LH || lt == LHU)
            return off[0];
        return 1'b0;
    endfunction

    function automatic word_t expect_wb(w_sel_t s, word_t ld, logic fwd);
        case (s)
            W_SEL_DLOAD: return fwd ? 32'h0 : ld;
            W_SEL_PC4:   return pc4;
            W_SEL_IMM_U: return imm_u;
            W_SEL_ALU:   return alu_out;
            default:     return csr_rdata;
        endcase
    endfunction

    // Wrong target or wrong direction both count
    function automatic logic expect_mispredict(logic pred, logic taken, word_t pred_addr,
                                               word_t target);
        if (pred_addr !== target)
            return 1'b1;
        return pred ^ taken;
    endfunction

    function automatic logic expect_jalr(word_t ins);
        if (ins[6:0] != JALR_OPCODE)
            return 1'b0;
        case (ins[19:15])
            5'd1, 5'd5: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    // Observes the flush side just before each rising edge
    always begin
        @(negedge CLK);
        #9;
        if (icache_flush) begin
            cnt_if = cnt_if + 1;
            dly_if = 1 + ($unsigned($random(seed)) % 5);
        end
        if (dcache_flush) begin
            cnt_df = cnt_df + 1;
            dly_df = 1 + ($unsigned($random(seed)) % 5);
        end
        if (itlb_fence) begin
            cnt_it = cnt_it + 1;
            dly_it = 1 + ($unsigned($random(seed)) % 5);
        end
        if (dtlb_fence) begin
            cnt_dt = cnt_dt + 1;
            dly_dt = 1 + ($unsigned($random(seed)) % 5);
        end
        if (iflush_done) seen_if = 1'b1;
        if (dflush_done) seen_df = 1'b1;
        if (itlb_done) seen_it = 1'b1;
        if (dtlb_done) seen_dt = 1'b1;
    end

    // Cache and TLB model, one done pulse after a random delay
    always @(negedge CLK) begin
        iflush_done <= 1'b0;
        dflush_done <= 1'b0;
        itlb_done   <= 1'b0;
        dtlb_done   <= 1'b0;
        if (dly_if > 0) begin
            dly_if = dly_if - 1;
            if (dly_if == 0) iflush_done <= 1'b1;
        end
        if (dly_df > 0) begin
            dly_df = dly_df - 1;
            if (dly_df == 0) dflush_done <= 1'b1;
        end
        if (dly_it > 0) begin
            dly_it = dly_it - 1;
            if (dly_it == 0) itlb_done <= 1'b1;
        end
        if (dly_dt > 0) begin
            dly_dt = dly_dt - 1;
            if (dly_dt == 0) dtlb_done <= 1'b1;
        end
    end

    task automatic run_fence(input logic tlb);
        integer cyc;
        integer base_a;
        integer base_b;
        base_a = tlb ? cnt_it : cnt_if;
        base_b = tlb ? cnt_dt : cnt_df;
        @(negedge CLK);
        seen_if = 1'b0;
        seen_df = 1'b0;
        seen_it = 1'b0;
        seen_dt = 1'b0;
        if (tlb) sfence = 1'b1;
        else ifence = 1'b1;
        #8;
        check_word("pulse_a", tlb ? itlb_fence : icache_flush, 32'h1);
        check_word("pulse_b", tlb ? dtlb_fence : dcache_flush, 32'h1);
        @(negedge CLK);
        #8;
        check_word("fence_stall", fence_stall, 32'h1);
        cyc = 0;
        while (fence_stall && cyc < 60) begin
            @(negedge CLK);
            #8;
            cyc = cyc + 1;
        end
        if (fence_stall) begin
            $display("timeout: fence_stall never fell after the fence");
            errors = errors + 1;
        end else if (tlb ? !(seen_it && seen_dt) : !(seen_if && seen_df)) begin
            $display("fence_stall fell before both completions were seen");
            errors = errors + 1;
        end
        // Request held a little longer, no new pulse expected
        repeat (3) @(negedge CLK);
        ifence = 1'b0;
        sfence = 1'b0;
        repeat (2) @(negedge CLK);
        check_word("pulse_a count", (tlb ? cnt_it : cnt_if) - base_a, 32'h1);
        check_word("pulse_b count", (tlb ? cnt_dt : cnt_df) - base_b, 32'h1);
    endtask

    initial begin
        load_type_t lt_all[5];
        load_type_t lt;
        logic [1:0] off;
        logic       wr;
        integer     i;
        integer     k;
        lt_all = '{LB, LH, LW, LBU, LHU};
        seed = 32'hd0302150;
        errors = 0;
        {cnt_if, cnt_df, cnt_it, cnt_dt} = '0;
        {dly_if, dly_df, dly_it, dly_dt} = '0;
        {seen_if, seen_df, seen_it, seen_dt} = '0;
        nRST = 1'b0;
        {valid, dren, dwen, reg_write_in, branch, branch_taken, prediction} = '0;
        {ifence, sfence, halt_in, suppress_data, dmem_busy, dmem_error} = '0;
        {iflush_done, dflush_done, itlb_done, dtlb_done} = '0;
        {pc, pc4, instr, alu_out, rs2_data, imm_u, predicted_addr, brj_addr} = '0;
        csr_rdata = '0;
        dmem_rdata = '0;
        rd_in = '0;
        load_type = LW;
        w_sel = W_SEL_ALU;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // Loads and stores of every width and offset
        for (i = 0; i < 160; i = i + 1) begin
            @(negedge CLK);
            wr = (i >= 100);
            lt = wr ? lt_all[i % 3] : lt_all[i % 5];
            off = 2'(i / 5);
            alu_out = {$random(seed)} & 32'hfffffffc | off;
            rs2_data = $random(seed);
            dmem_rdata = $random(seed);
            load_type = lt;
            dren = !wr;
            dwen = wr;
            w_sel = W_SEL_DLOAD;
            reg_write_in = 1'b1;
            suppress_data = (i % 7 == 3);
            #8;
            check_word("dmem_addr", dmem_addr, alu_out);
            if (suppress_data) begin
                check_word("dmem_ren", dmem_ren, 32'h0);
                check_word("dmem_wen", dmem_wen, 32'h0);
                check_word("reg_write", reg_write, 32'h0);
            end else begin
                check_word("dmem_ren", dmem_ren, !wr);
                check_word("dmem_wen", dmem_wen, wr);
                check_word("dmem_byte_en", dmem_byte_en, expect_byte_en(lt, off, !wr));
                check_word("mal_load", mal_load, !wr && expect_misaligned(lt, off));
                check_word("mal_store", mal_store, wr && expect_misaligned(lt, off));
                check_word("reg_write", reg_write, 32'h1);
                if (wr)
                    check_word("dmem_wdata", dmem_wdata, expect_wdata(lt, rs2_data));
                else if (!expect_misaligned(lt, off))
                    check_word("reg_wdata", reg_wdata,
                               expect_wb(W_SEL_DLOAD, expect_load(lt, off, dmem_rdata), 0));
            end
        end
        suppress_data = 1'b0;

        // Bus errors and back-pressure
        for (i = 0; i < 12; i = i + 1) begin
            @(negedge CLK);
            load_type = LW;
            alu_out = {$random(seed)} & 32'hfffffffc;
            dren = i[0];
            dwen = !i[0];
            dmem_error = i[1];
            dmem_busy = i[2];
            #8;
            check_word("fault_load", fault_load, i[0] && i[1]);
            check_word("fault_store", fault_store, !i[0] && i[1]);
            check_word("mem_busy", mem_busy, i[2]);
        end
        {dren, dwen, dmem_error, dmem_busy} = '0;

        // Writeback and forwarding sources
        for (k = 0; k < 5; k = k + 1) begin
            @(negedge CLK);
            w_sel = w_sel_t'(k);
            load_type = LW;
            dren = 1'b1;
            alu_out = {$random(seed)} & 32'hfffffffc;
            dmem_rdata = $random(seed);
            pc4 = $random(seed);
            imm_u = $random(seed) & 32'hfffff000;
            csr_rdata = $random(seed);
            #8;
            check_word("reg_wdata", reg_wdata, expect_wb(w_sel, dmem_rdata, 0));
            check_word("fw_data", fw_data, expect_wb(w_sel, dmem_rdata, 1));
        end
        dren = 1'b0;

        // Branch outcome and predictor update
        for (i = 0; i < 40; i = i + 1) begin
            @(negedge CLK);
            valid = $random(seed);
            branch = $random(seed);
            branch_taken = $random(seed);
            prediction = $random(seed);
            halt_in = $random(seed);
            rd_in = $random(seed);
            pc = $random(seed);
            brj_addr = $random(seed);
            predicted_addr = (i % 3 == 0) ? $random(seed) : brj_addr;
            instr = $random(seed);
            // JALR through ra, another register, t0, then a non-JALR through ra
            if (i % 4 != 3) instr[6:0] = JALR_OPCODE;
            if (i % 4 == 0) instr[19:15] = 5'd1;
            if (i % 4 == 1) instr[19:15] = 5'd6 + 5'(i % 8);
            if (i % 4 == 2) instr[19:15] = 5'd5;
            if (i % 4 == 3) instr[19:15] = 5'd1;
            #8;
            check_word("mispredict", mispredict,
                       expect_mispredict(prediction, branch_taken, predicted_addr, brj_addr));
            check_word("update_predictor", update_predictor, branch && valid);
            check_word("update_taken", update_taken, branch_taken);
            check_word("update_addr", update_addr, brj_addr);
            check_word("update_pc", update_pc, pc);
            check_word("update_direction", update_direction, instr[31]);
            check_word("is_jalr", is_jalr, expect_jalr(instr));
            check_word("halt", halt, halt_in);
            check_word("rd", rd, rd_in);
        end

        run_fence(1'b0);
        run_fence(1'b1);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
